//--- fetch_frontend.f
+incdir+hw
hw/frontend_pkg.sv
hw/fetch_pc.sv
hw/cacheline_adapter.sv
hw/icache.sv
hw/fetch_queue.sv
hw/fetch_frontend.sv
dv/tb_fetch_frontend.sv

//--- Bender.yml
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - hw
    files:
      - hw/frontend_pkg.sv
      - hw/fetch_pc.sv
      - hw/cacheline_adapter.sv
      - hw/icache.sv
      - hw/fetch_queue.sv
      - hw/fetch_frontend.sv
  - target: test
    include_dirs:
      - hw
    files:
      - dv/tb_fetch_frontend.sv

//--- dv/tb_fetch_frontend.sv
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module tb_fetch_frontend
import frontend_pkg::*;
();

    localparam logic [31:0] MEM_KEY = 32'h13579bdf;  // word at byte address A is A ^ key
    localparam int NUM_STEPS = 6;

    typedef struct packed {
        logic       redirect;
        addr_t      target;
        logic [7:0] takes;
        logic [7:0] hold;      // stalled cycles before the first take
        logic [7:0] mask;      // take allowed when bit (cycle % 8) is set
        addr_t      first_pc;
        logic [7:0] reads;     // new line reads inside the span of this step
    } step_t;

    step_t steps [NUM_STEPS] = '{
        '{1'b0, 32'h00000000, 8'd16, 8'd0,  8'hff, 32'h1eceb000, 8'd2},  // sequential from reset
        '{1'b1, 32'h1eceb080, 8'd16, 8'd0,  8'hb5, 32'h1eceb080, 8'd2},  // line 040 miss in flight
        '{1'b1, 32'h1eceb008, 8'd8,  8'd0,  8'hff, 32'h1eceb008, 8'd0},  // sets 0 and 1 still hit
        '{1'b1, 32'h1eceb200, 8'd8,  8'd0,  8'hff, 32'h1eceb200, 8'd1},  // set 0, other tag
        '{1'b1, 32'h1eceb000, 8'd4,  8'd0,  8'hff, 32'h1eceb000, 8'd1},  // evicted line again
        '{1'b1, 32'h1eceb110, 8'd16, 8'd80, 8'hff, 32'h1eceb110, 8'd3}   // queue fills up
    };

    logic          clk = 1'b0;
    logic          rst;
    addr_t         bmem_addr;
    logic          bmem_read;
    logic          bmem_ready;
    beat_t         bmem_rdata;
    logic          bmem_rvalid;
    logic          redirect;
    addr_t         redirect_pc;
    logic          inst_valid;
    fetch_packet_t inst_packet;
    logic          inst_take;

    logic [31:0] lfsr = 32'h97cc_be4c;
    int          errors = 0;
    int          cycle_count;
    int          beat_idx = 0;
    addr_t       exp_pc = `FE_RESET_PC;
    logic        lead_check = 1'b0;
    addr_t       read_log [$];
    addr_t       fill_q [$];  // lines still owed to the DUT

    fetch_frontend uut (
        .clk(clk), .rst(rst),
        .bmem_addr_o(bmem_addr), .bmem_read_o(bmem_read), .bmem_ready_i(bmem_ready),
        .bmem_rdata_i(bmem_rdata), .bmem_rvalid_i(bmem_rvalid),
        .redirect_i(redirect), .redirect_pc_i(redirect_pc),
        .inst_valid_o(inst_valid), .inst_packet_o(inst_packet), .inst_take_i(inst_take)
    );

    always #2 clk = ~clk;

    function automatic logic next_rand_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];  // x^32 + x^22 + x^2 + x + 1
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic beat_t mem_beat(input addr_t a);
        return {(a + 32'd4) ^ MEM_KEY, a ^ MEM_KEY};
    endfunction

    always @(negedge clk) begin
        if (!rst && bmem_read) begin
            assert (bmem_ready) else begin
                errors++;
                $display("bmem read issued while bmem_ready_i was low");
            end
            assert (bmem_addr[4:0] == 5'd0) else begin
                errors++;
                $display("bmem read address %h is not line aligned", bmem_addr);
            end
            assert (!lead_check || $signed(bmem_addr - exp_pc) <= 4 * `FE_QUEUE_DEPTH) else begin
                errors++;
                $display("bmem read of line %h runs too far ahead of pc %h", bmem_addr, exp_pc);
            end
            read_log.push_back(bmem_addr);
            fill_q.push_back(bmem_addr);
        end
    end

    always @(posedge clk) begin
        #1;
        bmem_ready  = next_rand_bit() | next_rand_bit();  // ready about 3 cycles in 4
        bmem_rvalid = 1'b0;
        if (fill_q.size() > 0 && next_rand_bit()) begin
            bmem_rdata  = mem_beat(fill_q[0] + 32'(8 * beat_idx));
            bmem_rvalid = 1'b1;
            if (beat_idx == `FE_BEATS - 1) begin
                beat_idx = 0;
                void'(fill_q.pop_front());
            end else begin
                beat_idx++;
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
        inst_take = 1'b0;
        redirect  = 1'b0;
    endtask

    task automatic run_step(input int idx, input step_t s);
        int    mark;
        int    cyc;
        int    taken;
        int    got_reads;
        addr_t want;
        logic  seen_valid;
        mark       = read_log.size();
        seen_valid = 1'b0;
        if (s.redirect) begin
            next_cycle();
            redirect    = 1'b1;
            redirect_pc = s.target;
            exp_pc      = s.target;
        end
        for (cyc = 0; cyc < s.hold; cyc++) begin
            next_cycle();
            assert (!seen_valid || inst_valid) else begin
                errors++;
                $display("step %0d: inst_valid_o dropped while the consumer stalled", idx);
            end
            seen_valid = seen_valid || inst_valid;
            lead_check = seen_valid;  // old path is drained once new packets arrive
        end
        lead_check = 1'b0;
        taken      = 0;
        cyc        = 0;
        while (taken < s.takes) begin
            next_cycle();
            if (s.mask[cyc % 8] && inst_valid) begin
                want = (taken == 0) ? s.first_pc : exp_pc;
                assert (inst_packet.pc == want) else begin
                    errors++;
                    $display("mismatch inst_packet_o.pc: got %h expected %h", inst_packet.pc, want);
                end
                assert (inst_packet.inst == (want ^ MEM_KEY)) else begin
                    errors++;
                    $display("mismatch inst_packet_o.inst: got %h expected %h",
                             inst_packet.inst, want ^ MEM_KEY);
                end
                inst_take = 1'b1;
                exp_pc    = want + 32'd4;
                taken++;
            end
            cyc++;
        end
        got_reads = 0;
        for (int i = mark; i < read_log.size(); i++) begin
            if (read_log[i] >= (s.first_pc & ~32'h1f) &&
                read_log[i] <= ((exp_pc - 32'd4) & ~32'h1f)) begin
                got_reads++;
            end
        end
        assert (got_reads == s.reads) else begin
            errors++;
            $display("mismatch bmem_read_o count in step %0d: got %h expected %h",
                     idx, got_reads, s.reads);
        end
    endtask

    task automatic close_run(input logic timed_out);
        $display("errors %0d, bmem reads %0d, timeout %0d", errors, read_log.size(), timed_out);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    initial begin
        int limit;
        limit = 200;
        foreach (steps[i]) limit += 40 * int'(steps[i].takes);
        cycle_count = 0;
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the fetch stream stopped", cycle_count);
        close_run(1'b1);
    end

    initial begin
        rst         = 1'b1;
        bmem_ready  = 1'b0;
        bmem_rdata  = '0;
        bmem_rvalid = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        inst_take   = 1'b0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        foreach (steps[i]) run_step(i, steps[i]);
        close_run(1'b0);
    end

endmodule : tb_fetch_frontend

//--- hw/fetch_frontend.sv
`timescale 1ns/10ps

module fetch_frontend
import frontend_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    output addr_t         bmem_addr_o,
    output logic          bmem_read_o,
    input  logic          bmem_ready_i,
    input  beat_t         bmem_rdata_i,
    input  logic          bmem_rvalid_i,

    input  logic          redirect_i,
    input  addr_t         redirect_pc_i,

    output logic          inst_valid_o,
    output fetch_packet_t inst_packet_o,
    input  logic          inst_take_i
);

    logic          req;
    addr_t         req_addr;
    logic          resp;
    logic [31:0]   resp_inst;
    line_t         line;
    logic          line_valid;
    logic          enq;
    fetch_packet_t enq_packet;
    logic          q_empty;
    logic          q_full;

    assign inst_valid_o = !q_empty;

    fetch_pc fetch_pc_i (
        .clk(clk), .rst(rst),
        .full_i(q_full),
        .redirect_i(redirect_i), .redirect_pc_i(redirect_pc_i),
        .resp_i(resp), .resp_inst_i(resp_inst),
        .req_o(req), .req_addr_o(req_addr),
        .enq_o(enq), .enq_packet_o(enq_packet)
    );

    icache icache_i (
        .clk(clk), .rst(rst),
        .req_i(req), .req_addr_i(req_addr),
        .resp_o(resp), .resp_inst_o(resp_inst),
        .bmem_ready_i(bmem_ready_i), .bmem_addr_o(bmem_addr_o), .bmem_read_o(bmem_read_o),
        .line_i(line), .line_valid_i(line_valid)
    );

    cacheline_adapter adapter_i (
        .clk(clk), .rst(rst),
        .bmem_rdata_i(bmem_rdata_i), .bmem_rvalid_i(bmem_rvalid_i),
        .line_o(line), .line_valid_o(line_valid)
    );

    fetch_queue queue_i (
        .clk(clk), .rst(rst),
        .flush_i(redirect_i),
        .enq_i(enq), .enq_packet_i(enq_packet),
        .deq_i(inst_take_i && inst_valid_o),  // take while empty is ignored
        .head_o(inst_packet_o), .empty_o(q_empty), .full_o(q_full)
    );

endmodule : fetch_frontend

//--- hw/fetch_queue.sv
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module fetch_queue
import frontend_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          flush_i,
    input  logic          enq_i,
    input  fetch_packet_t enq_packet_i,
    input  logic          deq_i,

    output fetch_packet_t head_o,
    output logic          empty_o,
    output logic          full_o
);

    localparam int PTR_BITS = $clog2(`FE_QUEUE_DEPTH);
    localparam logic [PTR_BITS:0] DEPTH = (PTR_BITS + 1)'(`FE_QUEUE_DEPTH);

    fetch_packet_t       mem_q [`FE_QUEUE_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr_q;
    logic [PTR_BITS-1:0] rd_ptr_q;
    logic [PTR_BITS:0]   count_q;
    logic                do_enq;
    logic                do_deq;

    assign empty_o = (count_q == '0);
    assign full_o  = (count_q == DEPTH);
    assign do_deq  = deq_i && !empty_o;
    assign do_enq  = enq_i && !full_o;
    assign head_o  = mem_q[rd_ptr_q];

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            wr_ptr_q <= wr_ptr_q + PTR_BITS'(do_enq);  // depth is a power of two
            rd_ptr_q <= rd_ptr_q + PTR_BITS'(do_deq);
            count_q  <= count_q + (PTR_BITS + 1)'(do_enq) - (PTR_BITS + 1)'(do_deq);
        end
    end

    always_ff @(posedge clk) begin
        if (do_enq && !flush_i) begin
            mem_q[wr_ptr_q] <= enq_packet_i;
        end
    end

endmodule : fetch_queue

//--- hw/icache.sv
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module icache
import frontend_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  logic        req_i,
    input  addr_t       req_addr_i,
    output logic        resp_o,
    output logic [31:0] resp_inst_o,

    input  logic        bmem_ready_i,
    output addr_t       bmem_addr_o,
    output logic        bmem_read_o,

    input  line_t       line_i,
    input  logic        line_valid_i
);

    localparam int OFFSET_BITS = $clog2(`FE_LINE_BITS / 8);
    localparam int INDEX_BITS  = $clog2(`FE_SETS);
    localparam int TAG_BITS    = 32 - INDEX_BITS - OFFSET_BITS;

    typedef enum logic [1:0] {
        S_IDLE,
        S_LOOKUP,
        S_WAIT_READY,
        S_WAIT_FILL
    } state_t;

    state_t state_q, state_d;

    line_t                 data_q [`FE_SETS];
    logic [TAG_BITS-1:0]   tag_q  [`FE_SETS];
    logic [`FE_SETS-1:0]   valid_q;

    addr_t                 addr_q;  // address of the request being served
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0]   tag;
    logic [OFFSET_BITS-3:0] word_sel;
    logic                  hit;

    assign index    = addr_q[OFFSET_BITS +: INDEX_BITS];
    assign tag      = addr_q[31 -: TAG_BITS];
    assign word_sel = addr_q[OFFSET_BITS-1:2];
    assign hit      = valid_q[index] && (tag_q[index] == tag);

    assign resp_o      = (state_q == S_LOOKUP) && hit;
    assign resp_inst_o = data_q[index][word_sel*32 +: 32];
    assign bmem_addr_o = {tag, index, {OFFSET_BITS{1'b0}}};  // line aligned

    always_comb begin
        state_d     = state_q;
        bmem_read_o = 1'b0;
        unique case (state_q)
            S_IDLE: begin
                if (req_i) begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (hit) begin
                    state_d = S_IDLE;
                end else begin
                    bmem_read_o = bmem_ready_i;
                    state_d     = bmem_ready_i ? S_WAIT_FILL : S_WAIT_READY;
                end
            end
            S_WAIT_READY: begin
                if (bmem_ready_i) begin
                    bmem_read_o = 1'b1;
                    state_d     = S_WAIT_FILL;
                end
            end
            S_WAIT_FILL: begin
                if (line_valid_i) begin
                    state_d = S_LOOKUP;  // replay hits on the fresh line
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            valid_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == S_WAIT_FILL && line_valid_i) begin
                valid_q[index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_i) begin
            addr_q <= req_addr_i;
        end
        if (state_q == S_WAIT_FILL && line_valid_i) begin
            data_q[index] <= line_i;
            tag_q[index]  <= tag;
        end
    end

endmodule : icache

//--- hw/cacheline_adapter.sv
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module cacheline_adapter
import frontend_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  beat_t bmem_rdata_i,
    input  logic  bmem_rvalid_i,

    output line_t line_o,
    output logic  line_valid_o
);

    localparam int CNT_BITS = $clog2(`FE_BEATS);
    localparam logic [CNT_BITS-1:0] LAST_BEAT = CNT_BITS'(`FE_BEATS - 1);

    logic [CNT_BITS-1:0] cnt_q;  // beat slot for the next rvalid
    line_t               line_q;
    logic                valid_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= bmem_rvalid_i && (cnt_q == LAST_BEAT);
            if (bmem_rvalid_i) begin
                cnt_q <= cnt_q + 1'b1;  // wraps back to slot 0 after the last beat
            end
        end
    end

    // lowest address beat lands in the low slot
    always_ff @(posedge clk) begin
        if (bmem_rvalid_i) begin
            line_q[cnt_q*`FE_BEAT_BITS +: `FE_BEAT_BITS] <= bmem_rdata_i;
        end
    end

    assign line_o       = line_q;
    assign line_valid_o = valid_q;

endmodule : cacheline_adapter

//--- hw/fetch_pc.sv
`timescale 1ns/10ps
`include "frontend_cfg.svh"

module fetch_pc
import frontend_pkg::*;
(
    input  logic          clk,
    input  logic          rst,

    input  logic          full_i,
    input  logic          redirect_i,
    input  addr_t         redirect_pc_i,

    input  logic          resp_i,
    input  logic [31:0]   resp_inst_i,
    output logic          req_o,
    output addr_t         req_addr_o,

    output logic          enq_o,
    output fetch_packet_t enq_packet_o
);

    addr_t pc_q;
    logic  pending_q;  // one request in flight
    logic  drop_q;     // in-flight response belongs to the old path
    logic  accept;

    assign req_o      = !pending_q && !full_i && !redirect_i;
    assign req_addr_o = pc_q;

    assign accept       = resp_i && !drop_q && !redirect_i;  // redirect wins over enqueue
    assign enq_o        = accept;
    assign enq_packet_o = '{pc: pc_q, inst: resp_inst_i};

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q      <= `FE_RESET_PC;
            pending_q <= 1'b0;
            drop_q    <= 1'b0;
        end else begin
            if (redirect_i) begin
                pc_q <= redirect_pc_i;
            end else if (accept) begin
                pc_q <= pc_q + 32'd4;
            end

            if (req_o) begin
                pending_q <= 1'b1;
            end else if (resp_i) begin
                pending_q <= 1'b0;
            end

            if (resp_i) begin
                drop_q <= 1'b0;
            end else if (redirect_i && pending_q) begin
                drop_q <= 1'b1;  // cache still finishes, word is discarded
            end
        end
    end

endmodule : fetch_pc

//--- hw/frontend_pkg.sv
`include "frontend_cfg.svh"

package frontend_pkg;

    // byte address on both the cache and bmem side
    typedef logic [31:0] addr_t;

    // one full cache line as assembled by the adapter
    typedef logic [`FE_LINE_BITS-1:0] line_t;

    // one bmem burst beat
    typedef logic [`FE_BEAT_BITS-1:0] beat_t;

    // what dispatch consumes, one instruction with its pc
    typedef struct packed {
        addr_t       pc;
        logic [31:0] inst;
    } fetch_packet_t;

endpackage

//--- hw/frontend_cfg.svh
`ifndef FRONTEND_CFG_SVH
`define FRONTEND_CFG_SVH

// fetch starts here out of reset
`define FE_RESET_PC     32'h1eceb000

// cache line and bmem burst geometry
`define FE_LINE_BITS    256
`define FE_BEAT_BITS    64
`define FE_BEATS        4

// direct mapped, 16 sets of 32 bytes
`define FE_SETS         16

// instruction queue entries
`define FE_QUEUE_DEPTH  8

`endif
